// File: project.f
+incdir+test
rtl/wavenet_pkg.sv
rtl/sample_history.sv
rtl/activation_cache.sv
rtl/dilated_conv.sv
rtl/forward_pass_ctrl.sv
rtl/wavenet_top.sv
test/wavenet_tb.sv

// File: test/wavenet_model.svh
`ifndef WAVENET_MODEL_SVH
`define WAVENET_MODEL_SVH

// ------------------------------
// reference model state
// ------------------------------

// model_hist[0] is the newest sample
logic signed [sample_w-1:0] model_hist [num_taps];
// model_cache[age][ch], age 0 is the newest layer-0 vector
logic signed [sample_w-1:0] model_cache [cache_depth][num_ch];
// expected outputs after the latest pass
logic signed [sample_w-1:0] model_out [num_ch];

// cold start, every age reads as zero
task automatic model_reset();
    for (int i = 0; i < num_taps; i++) begin
        model_hist[i] = '0;
    end
    for (int a = 0; a < cache_depth; a++) begin
        for (int c = 0; c < num_ch; c++) begin
            model_cache[a][c] = '0;
        end
    end
    for (int c = 0; c < num_ch; c++) begin
        model_out[c] = '0;
    end
endtask

// nibble lookup, out ch outermost, then in ch, then tap
function automatic int weight_at(input bit layer1, input int oc, input int ic, input int tap);
    logic signed [weight_w-1:0] w;
    int idx;
    if (layer1) begin
        idx = (oc * num_ch + ic) * num_taps + tap;
        w = conv1_weights[idx*weight_w +: weight_w];
    end else begin
        idx = oc * num_taps + tap;
        w = conv0_weights[idx*weight_w +: weight_w];
    end
    return int'(w);
endfunction

// floor shift, clip to the sample range, relu on request
function automatic logic signed [sample_w-1:0] requantize(input int sum, input bit relu);
    int scaled;
    int hi;
    int lo;
    hi = 2**(sample_w-1) - 1;
    lo = -(2**(sample_w-1));
    scaled = sum >>> frac_shift;
    if (scaled > hi) begin
        scaled = hi;
    end else if (scaled < lo) begin
        scaled = lo;
    end
    if (relu && scaled < 0) begin
        scaled = 0;
    end
    return scaled[sample_w-1:0];
endfunction

// one full forward pass for a new sample
task automatic model_step(input logic signed [sample_w-1:0] s);
    int sum;
    logic signed [sample_w-1:0] l0 [num_ch];
    for (int i = num_taps - 1; i > 0; i--) begin
        model_hist[i] = model_hist[i-1];
    end
    model_hist[0] = s;
    // layer 0, four consecutive taps
    for (int oc = 0; oc < num_ch; oc++) begin
        sum = 0;
        for (int t = 0; t < num_taps; t++) begin
            sum += weight_at(1'b0, oc, 0, t) * int'(model_hist[t]);
        end
        l0[oc] = requantize(sum, 1'b1);
    end
    // age the cache, newest at 0
    for (int a = cache_depth - 1; a > 0; a--) begin
        for (int c = 0; c < num_ch; c++) begin
            model_cache[a][c] = model_cache[a-1][c];
        end
    end
    for (int c = 0; c < num_ch; c++) begin
        model_cache[0][c] = l0[c];
    end
    // layer 1, taps at ages 0, 4, 8, 12
    for (int oc = 0; oc < num_ch; oc++) begin
        sum = 0;
        for (int ic = 0; ic < num_ch; ic++) begin
            for (int t = 0; t < num_taps; t++) begin
                sum += weight_at(1'b1, oc, ic, t) * int'(model_cache[t*cache_dilation][ic]);
            end
        end
        model_out[oc] = requantize(sum, 1'b0);
    end
endtask

`endif

// File: test/wavenet_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wavenet_tb;
    import wavenet_pkg::*;

    localparam int timeout_cycles = 500;
    localparam int num_random = 200;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       sample_req;
    logic signed [sample_w-1:0] sample_in;
    wire                        sample_ack;
    wire signed [sample_w-1:0]  out0;
    wire signed [sample_w-1:0]  out1;
    wire signed [sample_w-1:0]  out2;
    wire signed [sample_w-1:0]  out3;
    integer                     seed = 32'he0d3_0ebe;

    `include "wavenet_model.svh"

    wavenet_top uut (
        .clk(clk), .rst(rst),
        .sample_req(sample_req),
        .sample_in(sample_in),
        .sample_ack(sample_ack),
        .sample_out0(out0),
        .sample_out1(out1),
        .sample_out2(out2),
        .sample_out3(out3)
    );

    // 100 ns period, first falling edge at 100 ns
    initial begin
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // checks
    // ------------------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_sample(input logic signed [sample_w-1:0] got,
                                input logic signed [sample_w-1:0] expected,
                                input string what);
        if (got !== expected) begin
            abort_run($sformatf("Fail at %0t: %s got %0d expected %0d",
                                $time, what, got, expected));
        end
    endtask

    task automatic check_ack(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            abort_run($sformatf("Fail at %0t: %s, sample_ack %b expected %b",
                                $time, what, got, expected));
        end
    endtask

    function automatic logic signed [sample_w-1:0] dut_channel(input int ch);
        case (ch)
            0:       return out0;
            1:       return out1;
            2:       return out2;
            default: return out3;
        endcase
    endfunction

    // all four channels against the model
    task automatic compare_outputs(input string tag);
        for (int c = 0; c < num_ch; c++) begin
            check_sample(dut_channel(c), model_out[c], $sformatf("%s channel %0d", tag, c));
        end
    endtask

    // ------------------------------
    // handshake driver
    // ------------------------------

    // one four-phase transfer followed by a short idle gap with req low
    task automatic run_pass(input logic signed [sample_w-1:0] s, input string tag);
        int cycles;
        int hold;
        int idle;
        @(negedge clk);
        check_ack(sample_ack, 1'b0, {tag, " ack before req"});
        sample_in = s;
        sample_req = 1'b1;
        model_step(s);
        cycles = 0;
        while (!sample_ack) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run("timeout waiting for sample_ack to rise");
            end
        end
        compare_outputs(tag);
        // ack must stay up as long as req does
        hold = $unsigned($random(seed)) % 4;
        repeat (hold) begin
            @(negedge clk);
            check_ack(sample_ack, 1'b1, {tag, " ack while req held"});
        end
        sample_req = 1'b0;
        cycles = 0;
        while (sample_ack) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                abort_run("timeout waiting for sample_ack to fall");
            end
        end
        // input wiggles while idle but the outputs must hold
        idle = 1 + $unsigned($random(seed)) % 4;
        repeat (idle) begin
            sample_in = $random(seed);
            @(negedge clk);
            check_ack(sample_ack, 1'b0, {tag, " ack while idle"});
            compare_outputs({tag, " idle hold"});
        end
    endtask

    task automatic random_run(input int count, input string tag);
        logic signed [sample_w-1:0] s;
        for (int n = 0; n < count; n++) begin
            s = $random(seed);
            run_pass(s, tag);
        end
    endtask

    task automatic level_run(input logic signed [sample_w-1:0] level, input int count,
                             input string tag);
        repeat (count) begin
            run_pass(level, tag);
        end
    endtask

    // async reset held for 16 cycles and the model restarts with it
    task automatic apply_reset();
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        model_reset();
        @(negedge clk);
        check_ack(sample_ack, 1'b0, "ack after reset");
        compare_outputs("after reset");
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        rst = 1'b1;
        sample_req = 1'b0;
        sample_in = '0;
        model_reset();
        apply_reset();

        random_run(num_random, "random");

        // saturation and relu clamping at full scale
        level_run(16'sh7fff, 16, "full positive");
        level_run(16'sh8000, 16, "full negative");
        level_run(16'sh7fff, 5, "positive again");

        random_run(20, "before reset");
        @(negedge clk);
        apply_reset();
        random_run(30, "after reset");

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/wavenet_top.sv
`timescale 1ns/1ps
`default_nettype none

module wavenet_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   sample_req,
    input  logic signed [wavenet_pkg::sample_w-1:0] sample_in,
    output logic                                   sample_ack,
    output wire signed [wavenet_pkg::sample_w-1:0]  sample_out0,
    output wire signed [wavenet_pkg::sample_w-1:0]  sample_out1,
    output wire signed [wavenet_pkg::sample_w-1:0]  sample_out2,
    output wire signed [wavenet_pkg::sample_w-1:0]  sample_out3
);
    import wavenet_pkg::*;

    logic                                 history_shift;
    logic                                 conv0_start;
    logic                                 conv0_done;
    logic                                 cache_push;
    logic                                 conv1_start;
    logic                                 conv1_done;
    logic [num_taps*sample_w-1:0]         history_taps;
    logic [num_ch*sample_w-1:0]           conv0_result;
    logic [num_taps*num_ch*sample_w-1:0]  cache_taps;

    // ------------------------------
    // layer 0, causal taps 0..3
    // ------------------------------

    sample_history u_history (
        .clk(clk), .rst(rst),
        .shift(history_shift),
        .sample_in(sample_in),
        .taps(history_taps)
    );

    dilated_conv #(.in_ch(1), .apply_relu(1'b1), .weights(conv0_weights)) u_conv0 (
        .clk(clk), .rst(rst),
        .start(conv0_start),
        .act_in(history_taps),
        .result(conv0_result),
        .done(conv0_done)
    );

    // ------------------------------
    // layer 1, dilation 4
    // ------------------------------

    activation_cache u_cache (
        .clk(clk), .rst(rst),
        .push(cache_push),
        .act_in(conv0_result),
        .taps(cache_taps)
    );

    // channel 0 of the held result is sample_out0
    dilated_conv #(.in_ch(num_ch), .apply_relu(1'b0), .weights(conv1_weights)) u_conv1 (
        .clk(clk), .rst(rst),
        .start(conv1_start),
        .act_in(cache_taps),
        .result({sample_out3, sample_out2, sample_out1, sample_out0}),
        .done(conv1_done)
    );

    // sequencing and req/ack
    forward_pass_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .sample_req(sample_req),
        .conv0_done(conv0_done),
        .conv1_done(conv1_done),
        .history_shift(history_shift),
        .conv0_start(conv0_start),
        .cache_push(cache_push),
        .conv1_start(conv1_start),
        .sample_ack(sample_ack)
    );

endmodule

`default_nettype wire

// File: rtl/forward_pass_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module forward_pass_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic sample_req,
    input  logic conv0_done,
    input  logic conv1_done,
    output logic history_shift,
    output logic conv0_start,
    output logic cache_push,
    output logic conv1_start,
    output logic sample_ack
);

    // ------------------------------
    // state encoding
    // ------------------------------

    localparam logic [3:0] st_idle    = 4'd0;
    localparam logic [3:0] st_shift   = 4'd1;
    localparam logic [3:0] st_start0  = 4'd2;
    localparam logic [3:0] st_wait0   = 4'd3;
    localparam logic [3:0] st_push    = 4'd4;
    localparam logic [3:0] st_start1  = 4'd5;
    localparam logic [3:0] st_wait1   = 4'd6;
    localparam logic [3:0] st_ack     = 4'd7;
    localparam logic [3:0] st_release = 4'd8;

    logic [3:0] state;
    logic [3:0] state_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // one pass per req, strictly in layer order
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (sample_req) begin
                    state_next = st_shift;
                end
            end
            st_shift:  state_next = st_start0;
            st_start0: state_next = st_wait0;
            st_wait0: begin
                if (conv0_done) begin
                    state_next = st_push;
                end
            end
            // conv0 result is stable here, cache takes it
            st_push:   state_next = st_start1;
            st_start1: state_next = st_wait1;
            st_wait1: begin
                if (conv1_done) begin
                    state_next = st_ack;
                end
            end
            // hold ack until the environment lets go of req
            st_ack: begin
                if (!sample_req) begin
                    state_next = st_release;
                end
            end
            // ack low for a cycle before a new req counts
            st_release: state_next = st_idle;
            default:    state_next = st_idle;
        endcase
    end

    // single-cycle strobes, each state lasts one clock
    assign history_shift = (state == st_shift);
    assign conv0_start = (state == st_start0);
    assign cache_push = (state == st_push);
    assign conv1_start = (state == st_start1);
    assign sample_ack = (state == st_ack);

endmodule

`default_nettype wire

// File: rtl/dilated_conv.sv
`timescale 1ns/1ps
`default_nettype none

module dilated_conv #(
    parameter int in_ch = 1,
    parameter bit apply_relu = 1'b0,
    parameter logic [wavenet_pkg::num_ch*in_ch*wavenet_pkg::num_taps*wavenet_pkg::weight_w-1:0]
        weights = '0
) (
    input  logic                                                       clk,
    input  logic                                                       rst,
    input  logic                                                       start,
    input  logic [in_ch*wavenet_pkg::num_taps*wavenet_pkg::sample_w-1:0] act_in,
    output logic [wavenet_pkg::num_ch*wavenet_pkg::sample_w-1:0]        result,
    output logic                                                       done
);
    import wavenet_pkg::*;

    // one bit minimum for the single-channel layer
    localparam int ic_w = (in_ch > 1) ? $clog2(in_ch) : 1;

    logic                                busy;
    logic [$clog2(num_ch)-1:0]           oc_cnt;
    logic [ic_w-1:0]                     ic_cnt;
    logic [$clog2(num_taps)-1:0]         tap_cnt;
    logic                                tap_end;
    logic                                ic_end;
    logic                                oc_end;
    int                                  w_idx;
    int                                  a_idx;
    logic signed [weight_w-1:0]          w_cur;
    logic signed [sample_w-1:0]          a_cur;
    logic signed [weight_w+sample_w-1:0] prod_q;
    logic                                prod_v;
    logic                                prod_last;
    logic [$clog2(num_ch)-1:0]           prod_oc;
    logic signed [acc_w-1:0]             acc;
    logic signed [acc_w-1:0]             acc_sum;

    // shift, clip to sample range, optional relu
    function automatic logic signed [sample_w-1:0] rescale(input logic signed [acc_w-1:0] sum);
        logic signed [acc_w-1:0]    shifted;
        logic signed [sample_w-1:0] sat;
        shifted = sum >>> frac_shift;
        if (shifted > 2**(sample_w-1) - 1) begin
            sat = {1'b0, {(sample_w-1){1'b1}}};
        end else if (shifted < -(2**(sample_w-1))) begin
            sat = {1'b1, {(sample_w-1){1'b0}}};
        end else begin
            sat = shifted[sample_w-1:0];
        end
        if (apply_relu && sat[sample_w-1]) begin
            sat = '0;
        end
        return sat;
    endfunction

    // ------------------------------
    // step counter
    // ------------------------------

    assign tap_end = (tap_cnt == num_taps - 1);
    assign ic_end = (ic_cnt == in_ch - 1);
    assign oc_end = (oc_cnt == num_ch - 1);

    // tap fastest, then input channel, then output channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            oc_cnt <= '0;
            ic_cnt <= '0;
            tap_cnt <= '0;
        end else if (start) begin
            busy <= 1'b1;
            oc_cnt <= '0;
            ic_cnt <= '0;
            tap_cnt <= '0;
        end else if (busy) begin
            if (!tap_end) begin
                tap_cnt <= tap_cnt + 1'b1;
            end else begin
                tap_cnt <= '0;
                if (!ic_end) begin
                    ic_cnt <= ic_cnt + 1'b1;
                end else begin
                    ic_cnt <= '0;
                    oc_cnt <= oc_cnt + 1'b1;
                    // last product of the last channel issued
                    if (oc_end) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    // operand select, act_in is tap-major with channels inside a tap
    always_comb begin
        w_idx = (int'(oc_cnt) * in_ch + int'(ic_cnt)) * num_taps + int'(tap_cnt);
        a_idx = int'(tap_cnt) * in_ch + int'(ic_cnt);
        w_cur = weights[w_idx*weight_w +: weight_w];
        a_cur = act_in[a_idx*sample_w +: sample_w];
    end

    // ------------------------------
    // multiply then accumulate
    // ------------------------------

    always_ff @(posedge clk) begin
        prod_q <= w_cur * a_cur;
    end

    // tags that travel with the registered product
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prod_v <= 1'b0;
            prod_last <= 1'b0;
            prod_oc <= '0;
        end else begin
            prod_v <= busy && !start;
            prod_last <= tap_end && ic_end;
            prod_oc <= oc_cnt;
        end
    end

    assign acc_sum = acc + prod_q;

    // write back one channel slot per output channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
            result <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                acc <= '0;
            end else if (prod_v) begin
                if (prod_last) begin
                    acc <= '0;
                    result[prod_oc*sample_w +: sample_w] <= rescale(acc_sum);
                    done <= (prod_oc == num_ch - 1);
                end else begin
                    acc <= acc_sum;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/activation_cache.sv
`timescale 1ns/1ps
`default_nettype none

module activation_cache (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                push,
    input  logic [wavenet_pkg::num_ch*wavenet_pkg::sample_w-1:0] act_in,
    output logic [wavenet_pkg::num_taps*wavenet_pkg::num_ch*wavenet_pkg::sample_w-1:0] taps
);
    import wavenet_pkg::*;

    // ------------------------------
    // history of layer-0 vectors
    // ------------------------------

    // entry i holds the vector pushed i passes ago
    logic [num_ch*sample_w-1:0] entries [cache_depth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // cold start, all ages read as zero
            for (int i = 0; i < cache_depth; i++) begin
                entries[i] <= '0;
            end
        end else if (push) begin
            entries[0] <= act_in;
            for (int i = 1; i < cache_depth; i++) begin
                entries[i] <= entries[i-1];
            end
        end
    end

    // ------------------------------
    // dilated taps
    // ------------------------------

    // tap t reads age t * cache_dilation, so 0, 4, 8, 12
    // oldest tap lands on the last entry
    always_comb begin
        for (int t = 0; t < num_taps; t++) begin
            taps[t*num_ch*sample_w +: num_ch*sample_w] = entries[t*cache_dilation];
        end
    end

endmodule

`default_nettype wire

// File: rtl/sample_history.sv
`timescale 1ns/1ps
`default_nettype none

module sample_history (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               shift,
    input  logic signed [wavenet_pkg::sample_w-1:0]            sample_in,
    output logic [wavenet_pkg::num_taps*wavenet_pkg::sample_w-1:0] taps
);
    import wavenet_pkg::*;

    // hist[0] is the newest sample
    logic signed [sample_w-1:0] hist [num_taps];

    // shift chain, moves only on the strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_taps; i++) begin
                hist[i] <= '0;
            end
        end else if (shift) begin
            hist[0] <= sample_in;
            // everything else ages by one
            for (int i = 1; i < num_taps; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    // flatten, tap 0 in the low bits
    always_comb begin
        for (int i = 0; i < num_taps; i++) begin
            taps[i*sample_w +: sample_w] = hist[i];
        end
    end

endmodule

`default_nettype wire

// File: rtl/wavenet_pkg.sv
`default_nettype none

package wavenet_pkg;

    // ------------------------------
    // datapath widths
    // ------------------------------

    // one audio sample, also every activation word
    localparam int sample_w = 16;
    // signed kernel weight
    localparam int weight_w = 4;
    // running sum, wide enough for 16 products per channel
    localparam int acc_w = 24;
    // rescale of the sum before saturation
    localparam int frac_shift = 2;

    // ------------------------------
    // network shape
    // ------------------------------

    localparam int num_ch = 4;
    localparam int num_taps = 4;
    // layer-1 taps sit this many passes apart
    localparam int cache_dilation = 4;
    // oldest tap is at age cache_dilation * (num_taps - 1)
    localparam int cache_depth = cache_dilation * (num_taps - 1) + 1;

    // ------------------------------
    // kernel weights
    // ------------------------------

    // one nibble per weight, weight 0 in the low bits
    // index = (out_ch * in_ch + in_ch_idx) * num_taps + tap, tap 0 newest

    // layer 0, one input channel, so 16 bits per output channel
    localparam logic [num_ch*num_taps*weight_w-1:0] conv0_weights = 64'h3a71_c52f_e463_9d1b;

    // layer 1, one 64-bit word per output channel, out ch 0 in the low word
    localparam logic [num_ch*num_ch*num_taps*weight_w-1:0] conv1_weights = {
        64'h1e2d_7c30_f541_a296,
        64'hb403_26e1_d57f_0c8a,
        64'h62f1_9a0e_37d4_c58b,
        64'h0d7a_e153_48bf_296c
    };

endpackage

`default_nettype wire
